// File: glb_param_pkg.sv
/*
 * Data path widths, depths and the vector types of the configuration loader.
 * Imported by every module that carries addresses, words or counts.
 */
package glb_param_pkg;

    // two banks, top tile address bit picks one
    localparam int NUM_BANKS       = 2;
    localparam int BANK_ADDR_WIDTH = 10;
    localparam int GLB_ADDR_WIDTH  = 11;
    localparam int WORD_CNT_WIDTH  = 12;

    // bitstream word is fabric address over fabric data
    localparam int BANK_DATA_WIDTH = 64;
    localparam int CFG_ADDR_WIDTH  = 32;
    localparam int CFG_DATA_WIDTH  = 32;

    localparam int FIFO_DEPTH      = 4;

    typedef logic [GLB_ADDR_WIDTH-1:0]  glb_addr_t;
    typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;
    typedef logic [WORD_CNT_WIDTH-1:0]  word_count_t;
    typedef logic [BANK_DATA_WIDTH-1:0] bank_data_t;
    typedef logic [CFG_ADDR_WIDTH-1:0]  cfg_addr_t;
    typedef logic [CFG_DATA_WIDTH-1:0]  cfg_data_t;
    typedef logic [2:0]                 fifo_count_t;

endpackage

// File: glb_cfg_pkg.sv
/*
 * Register map, AXI4-Lite response codes and state encodings of the loader.
 * Imported by the register block and the address generator.
 */
package glb_cfg_pkg;

    typedef logic [3:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // byte offsets
    localparam axil_addr_t REG_START_ADDR = 4'h0;
    localparam axil_addr_t REG_NUM_WORDS  = 4'h4;
    // bit 0 write-one-to-start
    localparam axil_addr_t REG_CTRL       = 4'h8;
    // bit 0 busy, bit 1 done, read only
    localparam axil_addr_t REG_STATUS     = 4'hc;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic {
        ADGN_IDLE,
        ADGN_RUN
    } adgn_state_e;

    // one instance per write channel and per read channel
    typedef enum logic {
        AXIL_IDLE,
        AXIL_RESP
    } axil_state_e;

endpackage

// File: glb_bank.sv
/*
 * One global buffer bank of 1024 x 64-bit bitstream words.
 * Host writes on the edge, reads return registered data one cycle later.
 */
`timescale 1ns/10ps

module glb_bank
    import glb_param_pkg::*;
(
    input  logic       clk,
    input  logic       wr_en,
    input  bank_addr_t wr_addr,
    input  bank_data_t wr_data,
    input  logic       rd_en,
    input  bank_addr_t rd_addr,
    output bank_data_t rd_data
);

    // sram array
    bank_data_t mem [2**BANK_ADDR_WIDTH];

    // host write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read data holds when not enabled
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: glb_cfg_regs.sv
/*
 * AXI4-Lite register block of the loader: start address, word count,
 * start command and busy/done status. Raises start_pulse for one cycle.
 */
`timescale 1ns/10ps

module glb_cfg_regs
    import glb_param_pkg::*;
    import glb_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        s_axil_awvalid,
    input  axil_addr_t  s_axil_awaddr,
    input  logic        s_axil_wvalid,
    input  axil_data_t  s_axil_wdata,
    input  logic        s_axil_bready,
    output logic        s_axil_awready,
    output logic        s_axil_wready,
    output logic        s_axil_bvalid,
    output logic [1:0]  s_axil_bresp,
    input  logic        s_axil_arvalid,
    input  axil_addr_t  s_axil_araddr,
    input  logic        s_axil_rready,
    output logic        s_axil_arready,
    output logic        s_axil_rvalid,
    output axil_data_t  s_axil_rdata,
    output logic [1:0]  s_axil_rresp,
    input  logic        done_pulse,
    output logic        start_pulse,
    output glb_addr_t   start_addr,
    output word_count_t num_words
);

    axil_state_e wr_state;
    axil_state_e rd_state;
    logic        wr_hs;
    logic        rd_hs;
    logic        wr_err;
    logic        rd_err;
    axil_data_t  rd_value;
    logic        busy;
    logic        done;

    // address and data accepted together, ack only in that cycle
    assign wr_hs          = (wr_state == AXIL_IDLE) && s_axil_awvalid && s_axil_wvalid;
    assign s_axil_awready = wr_hs;
    assign s_axil_wready  = wr_hs;
    assign s_axil_bvalid  = (wr_state == AXIL_RESP);

    assign rd_hs          = (rd_state == AXIL_IDLE) && s_axil_arvalid;
    assign s_axil_arready = rd_hs;
    assign s_axil_rvalid  = (rd_state == AXIL_RESP);

    // write decode, status is read only
    always_comb begin
        case (s_axil_awaddr)
            REG_START_ADDR, REG_NUM_WORDS, REG_CTRL: wr_err = 1'b0;
            default: wr_err = 1'b1;
        endcase
    end

    // read decode, unmapped reads as zero
    always_comb begin
        rd_err = 1'b0;
        case (s_axil_araddr)
            REG_START_ADDR: rd_value = axil_data_t'(start_addr);
            REG_NUM_WORDS:  rd_value = axil_data_t'(num_words);
            REG_CTRL:       rd_value = '0;
            REG_STATUS:     rd_value = axil_data_t'({done, busy});
            default: begin
                rd_value = '0;
                rd_err   = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_state    <= AXIL_IDLE;
            rd_state    <= AXIL_IDLE;
            start_addr  <= '0;
            num_words   <= '0;
            start_pulse <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
        end else begin
            // write channel
            if (wr_state == AXIL_IDLE && wr_hs) begin
                wr_state <= AXIL_RESP;
            end else if (wr_state == AXIL_RESP && s_axil_bready) begin
                wr_state <= AXIL_IDLE;
            end
            // read channel
            if (rd_state == AXIL_IDLE && rd_hs) begin
                rd_state <= AXIL_RESP;
            end else if (rd_state == AXIL_RESP && s_axil_rready) begin
                rd_state <= AXIL_IDLE;
            end
            // register writes, masked to field width
            if (wr_hs && s_axil_awaddr == REG_START_ADDR) begin
                start_addr <= s_axil_wdata[GLB_ADDR_WIDTH-1:0];
            end
            if (wr_hs && s_axil_awaddr == REG_NUM_WORDS) begin
                num_words <= s_axil_wdata[WORD_CNT_WIDTH-1:0];
            end
            // start ignored while a load runs
            start_pulse <= wr_hs && (s_axil_awaddr == REG_CTRL) && s_axil_wdata[0] && !busy;
            // busy from start to done, done sticky until next start
            if (start_pulse) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (done_pulse) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        if (wr_hs) begin
            s_axil_bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
        end
        if (rd_hs) begin
            s_axil_rdata <= rd_value;
            s_axil_rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

// File: glb_cfg_address_generator.sv
/*
 * Producer side of the loader. Walks tile addresses from start_addr,
 * reads one bank word per cycle under FIFO credit and pushes the returned
 * word from the bank that was read.
 */
`timescale 1ns/10ps

module glb_cfg_address_generator
    import glb_param_pkg::*;
    import glb_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start_pulse,
    input  glb_addr_t   start_addr,
    input  word_count_t num_words,
    output logic        bank_rd_en [NUM_BANKS],
    output bank_addr_t  bank_rd_addr,
    input  bank_data_t  bank_rd_data [NUM_BANKS],
    input  fifo_count_t fifo_count,
    output logic        fifo_push,
    output bank_data_t  fifo_wr_data
);

    adgn_state_e state;
    glb_addr_t   addr;
    word_count_t remaining;
    logic        credit_ok;
    logic        rd_issue;
    logic        rd_pending;
    logic        rd_bank;

    // occupancy plus the read in flight must stay below depth
    assign credit_ok = (int'(fifo_count) + int'(rd_pending)) < FIFO_DEPTH;
    assign rd_issue  = (state == ADGN_RUN) && (remaining != '0) && credit_ok;

    // bank decode on top address bit
    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank_rd_en[i] = rd_issue && (addr[GLB_ADDR_WIDTH-1] == 1'(i));
        end
    end
    assign bank_rd_addr = addr[BANK_ADDR_WIDTH-1:0];

    // returned word from the bank read last cycle
    assign fifo_push    = rd_pending;
    assign fifo_wr_data = bank_rd_data[rd_bank];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= ADGN_IDLE;
            addr       <= '0;
            remaining  <= '0;
            rd_pending <= 1'b0;
            rd_bank    <= 1'b0;
        end else begin
            rd_pending <= rd_issue;
            if (rd_issue) begin
                rd_bank <= addr[GLB_ADDR_WIDTH-1];
            end
            case (state)
                ADGN_IDLE: begin
                    if (start_pulse) begin
                        addr      <= start_addr;
                        remaining <= num_words;
                        state     <= ADGN_RUN;
                    end
                end
                ADGN_RUN: begin
                    if (rd_issue) begin
                        addr      <= addr + 1'b1;
                        remaining <= remaining - 1'b1;
                    end
                    // last read issued, its data is still pushed
                    if (remaining == '0) begin
                        state <= ADGN_IDLE;
                    end
                end
                default: state <= ADGN_IDLE;
            endcase
        end
    end

endmodule

// File: glb_bitstream_fifo.sv
/*
 * Four-entry bitstream word FIFO between bank reads and fabric writes.
 * Head entry is always visible on rd_data; count feeds the producer credit.
 */
`timescale 1ns/10ps

module glb_bitstream_fifo
    import glb_param_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        push,
    input  bank_data_t  wr_data,
    input  logic        pop,
    output bank_data_t  rd_data,
    output logic        empty,
    output fifo_count_t count
);

    bank_data_t                    mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic                          push_ok;
    logic                          pop_ok;

    assign empty   = (count == '0);
    assign push_ok = push && (count != FIFO_DEPTH);
    assign pop_ok  = pop && !empty;
    assign rd_data = mem[rd_ptr];

    // storage
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap on power-of-two depth
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: glb_cfg_writer.sv
/*
 * Consumer side of the loader. Presents the FIFO head as a fabric write,
 * pops on the completed handshake and pulses done after the last write.
 */
`timescale 1ns/10ps

module glb_cfg_writer
    import glb_param_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start_pulse,
    input  word_count_t num_words,
    input  logic        fifo_empty,
    input  bank_data_t  fifo_rd_data,
    output logic        fifo_pop,
    output logic        cfg_wr,
    output cfg_addr_t   cfg_addr,
    output cfg_data_t   cfg_data,
    input  logic        cfg_ready,
    output logic        done_pulse
);

    logic        active;
    word_count_t remaining;
    logic        wr_done;

    // head stays put until popped, so addr/data hold under stall
    assign cfg_wr   = active && !fifo_empty;
    assign wr_done  = cfg_wr && cfg_ready;
    assign fifo_pop = wr_done;
    assign cfg_addr = fifo_rd_data[BANK_DATA_WIDTH-1 -: CFG_ADDR_WIDTH];
    assign cfg_data = fifo_rd_data[CFG_DATA_WIDTH-1:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active     <= 1'b0;
            remaining  <= '0;
            done_pulse <= 1'b0;
        end else begin
            done_pulse <= 1'b0;
            if (start_pulse) begin
                remaining  <= num_words;
                active     <= (num_words != '0);
                // empty load finishes right away
                done_pulse <= (num_words == '0);
            end else if (wr_done) begin
                remaining <= remaining - 1'b1;
                if (remaining == word_count_t'(1)) begin
                    active     <= 1'b0;
                    done_pulse <= 1'b1;
                end
            end
        end
    end

endmodule

// File: glb_cfg_tile.sv
/*
 * Configuration loader of one global buffer tile: register block, two banks,
 * address generator, bitstream FIFO and configuration writer.
 */
`timescale 1ns/10ps

module glb_cfg_tile
    import glb_param_pkg::*;
    import glb_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        s_axil_awvalid,
    input  axil_addr_t  s_axil_awaddr,
    input  logic        s_axil_wvalid,
    input  axil_data_t  s_axil_wdata,
    input  logic        s_axil_bready,
    output logic        s_axil_awready,
    output logic        s_axil_wready,
    output logic        s_axil_bvalid,
    output logic [1:0]  s_axil_bresp,
    input  logic        s_axil_arvalid,
    input  axil_addr_t  s_axil_araddr,
    input  logic        s_axil_rready,
    output logic        s_axil_arready,
    output logic        s_axil_rvalid,
    output axil_data_t  s_axil_rdata,
    output logic [1:0]  s_axil_rresp,
    input  logic        host_wr_en,
    input  glb_addr_t   host_wr_addr,
    input  bank_data_t  host_wr_data,
    output logic        cfg_wr,
    output cfg_addr_t   cfg_addr,
    output cfg_data_t   cfg_data,
    input  logic        cfg_ready,
    output logic        cfg_done
);

    logic        start_pulse;
    glb_addr_t   start_addr;
    word_count_t num_words;
    logic        bank_rd_en [NUM_BANKS];
    bank_addr_t  bank_rd_addr;
    bank_data_t  bank_rd_data [NUM_BANKS];
    fifo_count_t fifo_count;
    logic        fifo_push;
    bank_data_t  fifo_wr_data;
    logic        fifo_pop;
    logic        fifo_empty;
    bank_data_t  fifo_rd_data;

    glb_cfg_regs regs_inst (
        .clk            (clk),
        .reset          (reset),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_bready  (s_axil_bready),
        .s_axil_awready (s_axil_awready),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_rready  (s_axil_rready),
        .s_axil_arready (s_axil_arready),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .done_pulse     (cfg_done),
        .start_pulse    (start_pulse),
        .start_addr     (start_addr),
        .num_words      (num_words)
    );

    // host write steered by top address bit
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        glb_bank bank_inst (
            .clk     (clk),
            .wr_en   (host_wr_en && (host_wr_addr[GLB_ADDR_WIDTH-1] == 1'(i))),
            .wr_addr (host_wr_addr[BANK_ADDR_WIDTH-1:0]),
            .wr_data (host_wr_data),
            .rd_en   (bank_rd_en[i]),
            .rd_addr (bank_rd_addr),
            .rd_data (bank_rd_data[i])
        );
    end

    glb_cfg_address_generator adgn_inst (
        .clk          (clk),
        .reset        (reset),
        .start_pulse  (start_pulse),
        .start_addr   (start_addr),
        .num_words    (num_words),
        .bank_rd_en   (bank_rd_en),
        .bank_rd_addr (bank_rd_addr),
        .bank_rd_data (bank_rd_data),
        .fifo_count   (fifo_count),
        .fifo_push    (fifo_push),
        .fifo_wr_data (fifo_wr_data)
    );

    glb_bitstream_fifo fifo_inst (
        .clk     (clk),
        .reset   (reset),
        .push    (fifo_push),
        .wr_data (fifo_wr_data),
        .pop     (fifo_pop),
        .rd_data (fifo_rd_data),
        .empty   (fifo_empty),
        .count   (fifo_count)
    );

    glb_cfg_writer writer_inst (
        .clk          (clk),
        .reset        (reset),
        .start_pulse  (start_pulse),
        .num_words    (num_words),
        .fifo_empty   (fifo_empty),
        .fifo_rd_data (fifo_rd_data),
        .fifo_pop     (fifo_pop),
        .cfg_wr       (cfg_wr),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .cfg_ready    (cfg_ready),
        .done_pulse   (cfg_done)
    );

endmodule

// File: glb_cfg_tile_asserts.sv
/*
 * Concurrent checks on the fabric and AXI write handshakes and the FIFO fill.
 * Bound into glb_cfg_tile by the testbench; failures are counted here.
 */
`timescale 1ns/10ps

module glb_cfg_tile_asserts
    import glb_param_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        cfg_wr,
    input logic        cfg_ready,
    input cfg_addr_t   cfg_addr,
    input cfg_data_t   cfg_data,
    input logic        s_axil_bvalid,
    input logic        s_axil_bready,
    input logic        fifo_push,
    input fifo_count_t fifo_count
);

    int assert_errors = 0;

    // stalled fabric write keeps its payload
    cfg_hold: assert property (@(posedge clk) disable iff (reset)
        cfg_wr && !cfg_ready |=> $stable(cfg_addr) && $stable(cfg_data))
        else begin
            assert_errors++;
            $error("cfg_addr or cfg_data changed during a stalled fabric write");
        end

    // write response waits for bready
    bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
        else begin
            assert_errors++;
            $error("bvalid dropped before bready");
        end

    // producer credit keeps the FIFO from overflowing
    fifo_no_overflow: assert property (@(posedge clk) disable iff (reset)
        fifo_push |-> fifo_count < FIFO_DEPTH)
        else begin
            assert_errors++;
            $error("push into a full bitstream FIFO");
        end

endmodule

// File: glb_cfg_tile_tb.sv
/*
 * Directed testbench of the tile configuration loader. Drives AXI4-Lite
 * and the host bank port, models the fabric and checks the write stream.
 */
`timescale 1ns/10ps

module glb_cfg_tile_tb
    import glb_param_pkg::*;
    import glb_cfg_pkg::*;
();

    logic        clk;
    logic        reset;
    logic        s_axil_awvalid;
    axil_addr_t  s_axil_awaddr;
    logic        s_axil_wvalid;
    axil_data_t  s_axil_wdata;
    logic        s_axil_bready;
    logic        s_axil_awready;
    logic        s_axil_wready;
    logic        s_axil_bvalid;
    logic [1:0]  s_axil_bresp;
    logic        s_axil_arvalid;
    axil_addr_t  s_axil_araddr;
    logic        s_axil_rready;
    logic        s_axil_arready;
    logic        s_axil_rvalid;
    axil_data_t  s_axil_rdata;
    logic [1:0]  s_axil_rresp;
    logic        host_wr_en;
    glb_addr_t   host_wr_addr;
    bank_data_t  host_wr_data;
    logic        cfg_wr;
    cfg_addr_t   cfg_addr;
    cfg_data_t   cfg_data;
    logic        cfg_ready;
    logic        cfg_done;

    // reference copy of every bank word the host wrote
    bank_data_t  model [2**GLB_ADDR_WIDTH];
    cfg_addr_t   got_addr [$];
    cfg_data_t   got_data [$];
    int          done_count;
    logic        ready_random;
    int          mismatch_count;
    int          timeout_count;
    int          aw_accepts = 0;
    int          ar_accepts = 0;

    glb_cfg_tile uut (.*);

    bind glb_cfg_tile glb_cfg_tile_asserts asserts_inst (
        .clk           (clk),
        .reset         (reset),
        .cfg_wr        (cfg_wr),
        .cfg_ready     (cfg_ready),
        .cfg_addr      (cfg_addr),
        .cfg_data      (cfg_data),
        .s_axil_bvalid (s_axil_bvalid),
        .s_axil_bready (s_axil_bready),
        .fifo_push     (fifo_push),
        .fifo_count    (fifo_count)
    );

    always #20 clk = ~clk;

    // AXI address handshakes as the slave takes them on the rising edge
    always @(posedge clk) begin
        if (s_axil_awvalid && s_axil_awready && s_axil_wvalid && s_axil_wready) begin
            aw_accepts++;
        end
        if (s_axil_arvalid && s_axil_arready) begin
            ar_accepts++;
        end
    end

    // one fabric step per falling edge
    task automatic tick();
        @(negedge clk);
        cfg_ready = ready_random ? 1'($urandom % 2) : 1'b1;
        // handshake completes on the coming rising edge
        if (cfg_wr && cfg_ready) begin
            got_addr.push_back(cfg_addr);
            got_data.push_back(cfg_data);
        end
        if (cfg_done) begin
            done_count++;
        end
    endtask

    task automatic check_cfg(string what, cfg_addr_t got_a, cfg_data_t got_d,
                             cfg_addr_t exp_a, cfg_data_t exp_d);
        if (got_a !== exp_a || got_d !== exp_d) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s got %h/%h expected %h/%h",
                     $time, what, got_a, got_d, exp_a, exp_d);
        end
    endtask

    task automatic check_reg(string what, axil_data_t got, axil_data_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(string what, logic [1:0] got, logic [1:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(string what, word_count_t got, word_count_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic axil_write(axil_addr_t addr, axil_data_t data, logic [1:0] exp_resp);
        int wait_cycles;
        int accepts_before;
        wait_cycles    = 0;
        accepts_before = aw_accepts;
        s_axil_awvalid = 1'b1;
        s_axil_awaddr  = addr;
        s_axil_wvalid  = 1'b1;
        s_axil_wdata   = data;
        s_axil_bready  = 1'b0;
        do begin
            tick();
            wait_cycles++;
        end while (!s_axil_bvalid && wait_cycles < 50);
        if (!s_axil_bvalid) begin
            timeout_count++;
            $display("timeout waiting for the AXI write response at %0t", $time);
        end
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        // response held back a cycle, bvalid has to wait for bready
        tick();
        check_resp($sformatf("write response offset %h", addr), s_axil_bresp, exp_resp);
        s_axil_bready = 1'b1;
        tick();
        s_axil_bready = 1'b0;
        check_count($sformatf("write handshakes offset %h", addr),
                    word_count_t'(aw_accepts - accepts_before), word_count_t'(1));
    endtask

    task automatic axil_read(axil_addr_t addr, axil_data_t exp_data, logic [1:0] exp_resp);
        int wait_cycles;
        int accepts_before;
        wait_cycles    = 0;
        accepts_before = ar_accepts;
        s_axil_arvalid = 1'b1;
        s_axil_araddr  = addr;
        s_axil_rready  = 1'b1;
        do begin
            tick();
            wait_cycles++;
        end while (!s_axil_rvalid && wait_cycles < 50);
        if (!s_axil_rvalid) begin
            timeout_count++;
            $display("timeout waiting for the AXI read data at %0t", $time);
        end
        check_reg($sformatf("read offset %h", addr), s_axil_rdata, exp_data);
        check_resp($sformatf("read response offset %h", addr), s_axil_rresp, exp_resp);
        s_axil_arvalid = 1'b0;
        tick();
        s_axil_rready = 1'b0;
        check_count($sformatf("read handshakes offset %h", addr),
                    word_count_t'(ar_accepts - accepts_before), word_count_t'(1));
    endtask

    task automatic bank_write(glb_addr_t addr, bank_data_t data);
        host_wr_en   = 1'b1;
        host_wr_addr = addr;
        host_wr_data = data;
        model[addr]  = data;
        tick();
        host_wr_en = 1'b0;
    endtask

    task automatic fill_random(glb_addr_t start, int n);
        for (int i = 0; i < n; i++) begin
            bank_write(glb_addr_t'(start + i), {$urandom, $urandom});
        end
    endtask

    task automatic start_load(glb_addr_t start, word_count_t n);
        got_addr.delete();
        got_data.delete();
        done_count = 0;
        axil_write(REG_START_ADDR, axil_data_t'(start), RESP_OKAY);
        axil_write(REG_NUM_WORDS, axil_data_t'(n), RESP_OKAY);
        axil_write(REG_CTRL, 32'h1, RESP_OKAY);
    endtask

    task automatic finish_load(glb_addr_t start, word_count_t n);
        int         wait_cycles;
        bank_data_t word;
        wait_cycles = 0;
        while (done_count == 0 && wait_cycles < 2000) begin
            tick();
            wait_cycles++;
        end
        if (done_count == 0) begin
            timeout_count++;
            $display("timeout waiting for cfg_done at %0t", $time);
        end
        // quiet window, late writes or a second pulse show up here
        repeat (10) tick();
        check_count("fabric writes", word_count_t'(got_addr.size()), n);
        check_count("done pulses", word_count_t'(done_count), word_count_t'(1));
        // upper half is the fabric address, lower half the data
        for (int i = 0; i < got_addr.size() && i < n; i++) begin
            word = model[glb_addr_t'(start + i)];
            check_cfg($sformatf("fabric write %0d", i), got_addr[i], got_data[i],
                      word[63:32], word[31:0]);
        end
        // done set, busy clear
        axil_read(REG_STATUS, 32'h2, RESP_OKAY);
    endtask

    task automatic run_load(glb_addr_t start, word_count_t n, logic rnd);
        ready_random = rnd;
        start_load(start, n);
        finish_load(start, n);
        ready_random = 1'b0;
    endtask

    task automatic test_reset_state();
        check_reg("cfg_wr and cfg_done after reset", axil_data_t'({cfg_wr, cfg_done}), '0);
        axil_read(REG_STATUS, 32'h0, RESP_OKAY);
        // masked to 11 and 12 bits
        axil_write(REG_START_ADDR, 32'h1234_5d3c, RESP_OKAY);
        axil_read(REG_START_ADDR, 32'h0000_053c, RESP_OKAY);
        axil_write(REG_NUM_WORDS, 32'habcd_e9a5, RESP_OKAY);
        axil_read(REG_NUM_WORDS, 32'h0000_09a5, RESP_OKAY);
        axil_read(4'h6, 32'h0, RESP_SLVERR);
        axil_write(REG_STATUS, 32'h3, RESP_SLVERR);
        axil_write(4'ha, 32'h1, RESP_SLVERR);
        axil_read(REG_STATUS, 32'h0, RESP_OKAY);
    endtask

    task automatic test_zero_and_busy();
        run_load(glb_addr_t'(0), word_count_t'(0), 1'b0);
        fill_random(glb_addr_t'(300), 16);
        start_load(glb_addr_t'(300), word_count_t'(16));
        // busy now, done cleared by the start
        axil_read(REG_STATUS, 32'h1, RESP_OKAY);
        axil_write(REG_START_ADDR, 32'd500, RESP_OKAY);
        axil_write(REG_CTRL, 32'h1, RESP_OKAY);
        finish_load(glb_addr_t'(300), word_count_t'(16));
    endtask

    initial begin
        // fixed seed for the whole run
        void'($urandom(32'hd915));
        clk            = 1'b0;
        reset          = 1'b1;
        s_axil_awvalid = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_wdata   = '0;
        s_axil_bready  = 1'b0;
        s_axil_arvalid = 1'b0;
        s_axil_araddr  = '0;
        s_axil_rready  = 1'b0;
        host_wr_en     = 1'b0;
        host_wr_addr   = '0;
        host_wr_data   = '0;
        cfg_ready      = 1'b1;
        ready_random   = 1'b0;
        done_count     = 0;
        mismatch_count = 0;
        timeout_count  = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        // basic load from bank 0
        fill_random(glb_addr_t'(0), 8);
        run_load(glb_addr_t'(0), word_count_t'(8), 1'b0);
        // crosses from bank 0 into bank 1 at 1024
        fill_random(glb_addr_t'(1020), 10);
        run_load(glb_addr_t'(1020), word_count_t'(10), 1'b0);
        // fabric back-pressure
        fill_random(glb_addr_t'(100), 20);
        run_load(glb_addr_t'(100), word_count_t'(20), 1'b1);
        test_zero_and_busy();

        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatch_count, timeout_count, uut.asserts_inst.assert_errors);
        if (mismatch_count + timeout_count + uut.asserts_inst.assert_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
glb_param_pkg.sv
glb_cfg_pkg.sv
glb_bank.sv
glb_cfg_regs.sv
glb_cfg_address_generator.sv
glb_bitstream_fifo.sv
glb_cfg_writer.sv
glb_cfg_tile.sv
glb_cfg_tile_asserts.sv
glb_cfg_tile_tb.sv
